/* tb.f */
+incdir+.
rd_capture_pkg.sv
dqs_delay_line.sv
rd_byte_lane.sv
apb_capture_regs.sv
rd_capture_top.sv
tb_rd_capture.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/10ps
TOP      := tb_rd_capture
FILELIST := tb.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST)) tb_rd_capture_table.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '>>> PASS' $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_rd_capture_table.svh */
localparam int NUM_ROWS = 9;

// One set_row call per row with the columns row, tap, sample_en, mask,
// words per lane, random bytes, lane 0 words {w3,w2,w1,w0},
// lane 1 words {w3,w2,w1,w0}, expected read words {e2,e1,e0}
// and expected capture count per lane
// Each lane word is {falling byte, rising byte}
task automatic load_table();
  // Three-word burst at taps 0, 3 and 7
  set_row(0, 3'd0, 1'b1, 1'b1, 3, 1'b0,
          64'h0000_E5F6_C3D4_A1B2, 64'h0000_5566_3344_1122,
          96'h55E566F6_33C344D4_11A122B2, 8'd3);
  set_row(1, 3'd3, 1'b1, 1'b1, 3, 1'b0,
          64'h0000_E5F6_C3D4_A1B2, 64'h0000_5566_3344_1122,
          96'h55E566F6_33C344D4_11A122B2, 8'd3);
  set_row(2, 3'd7, 1'b1, 1'b1, 3, 1'b0,
          64'h0000_E5F6_C3D4_A1B2, 64'h0000_5566_3344_1122,
          96'h55E566F6_33C344D4_11A122B2, 8'd3);
  // Mask low and then sample enable low so the bank keeps its words
  set_row(3, 3'd0, 1'b1, 1'b0, 3, 1'b0,
          64'h0000_CAFE_BEEF_DEAD, 64'h0000_FACE_F00D_0BAD,
          96'h55E566F6_33C344D4_11A122B2, 8'd0);
  set_row(4, 3'd2, 1'b0, 1'b1, 3, 1'b0,
          64'h0000_2468_9BDF_1357, 64'h0000_0F0F_BDF1_ACE0,
          96'h55E566F6_33C344D4_11A122B2, 8'd0);
  // Fourth word lands in entry 0
  set_row(5, 3'd1, 1'b1, 1'b1, 4, 1'b0,
          64'h0708_0506_0304_0102, 64'hE7F8_C5D6_A3B4_8192,
          96'hC505D606_A303B404_E707F808, 8'd4);
  // Single word leaves entries 1 and 2 from the row before
  set_row(6, 3'd5, 1'b1, 1'b1, 1, 1'b0,
          64'h0000_0000_0000_5AA5, 64'h0000_0000_0000_3CC3,
          96'hC505D606_A303B404_3C5AC3A5, 8'd1);
  // Random bytes with expected words filled in at run time
  set_row(7, 3'd4, 1'b1, 1'b1, 2, 1'b1, 64'h0, 64'h0, 96'h0, 8'd0);
  set_row(8, 3'd6, 1'b1, 1'b1, 4, 1'b1, 64'h0, 64'h0, 96'h0, 8'd0);
endtask

/* tb_rd_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rd_capture
  import rd_capture_pkg::*;
;

  `include "tb_rd_capture_table.svh"

  localparam int HOLD_CYCLES = 10;      // Covers tap 7 plus edge detect

  logic                     dly_dqs_proc;
  logic                     hresetn;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [APB_AW-1:0]        paddr;
  logic [31:0]              pwdata;
  logic [31:0]              prdata;
  logic                     pready;
  logic                     pslverr;
  logic [LANES-1:0]         s_dqs_rd;
  logic [LANES*LANE_W-1:0]  s_data_rd;
  logic                     s_rd_dqs_mask;
  logic                     s_rd_start;
  logic                     s_rd_pop;
  logic                     s_rd_end;
  logic [RD_W-1:0]          s_rd_data;

  logic [TAP_W-1:0] row_tap   [NUM_ROWS];
  logic             row_en    [NUM_ROWS];
  logic             row_mask  [NUM_ROWS];
  int               row_words [NUM_ROWS];
  logic             row_rnd   [NUM_ROWS];
  logic [63:0]      row_l0    [NUM_ROWS];
  logic [63:0]      row_l1    [NUM_ROWS];
  logic [95:0]      row_exp   [NUM_ROWS];
  logic [7:0]       row_cnt   [NUM_ROWS];

  logic [31:0] model_bank [BANK_DEPTH];   // Expected interleaved entries
  int          seed = 32'hbff11c90;
  int          mismatches = 0;
  int          failures = 0;

  rd_capture_top i_rd_capture_top (
    .dly_dqs_proc  (dly_dqs_proc),
    .hresetn       (hresetn),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .s_dqs_rd      (s_dqs_rd),
    .s_data_rd     (s_data_rd),
    .s_rd_dqs_mask (s_rd_dqs_mask),
    .s_rd_start    (s_rd_start),
    .s_rd_pop      (s_rd_pop),
    .s_rd_end      (s_rd_end),
    .s_rd_data     (s_rd_data)
  );

  initial
  begin
    dly_dqs_proc = 1'b0;
    forever #5 dly_dqs_proc = ~dly_dqs_proc;
  end

  initial
  begin
    repeat (NUM_ROWS * 200) @(posedge dly_dqs_proc);
    $display("Watchdog expired after %0d cycles, the tests did not complete",
             NUM_ROWS * 200);
    $display(">>> FAIL");
    $finish;
  end

  task automatic set_row(input int idx, input logic [TAP_W-1:0] tap, input logic en,
                         input logic mask, input int words, input logic rnd,
                         input logic [63:0] l0, input logic [63:0] l1,
                         input logic [95:0] exp, input logic [7:0] cnt);
    row_tap[idx]   = tap;
    row_en[idx]    = en;
    row_mask[idx]  = mask;
    row_words[idx] = words;
    row_rnd[idx]   = rnd;
    row_l0[idx]    = l0;
    row_l1[idx]    = l1;
    row_exp[idx]   = exp;
    row_cnt[idx]   = cnt;
  endtask

  task automatic tick();
    @(posedge dly_dqs_proc);
    #1;                                  // Drive point after the edge
  endtask

  task automatic check32(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    waited  = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    tick();
    penable = 1'b1;                      // Access phase
    while (!pready && waited < 4)
    begin
      tick();
      waited++;
    end
    if (!pready)
    begin
      $display("APB access to offset 0x%h never saw pready", addr);
      failures++;
    end
    rdata = prdata;
    err   = pslverr;
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    check32("pslverr", {31'b0, err}, 32'h0);
  endtask

  task automatic apb_read_check(input logic [APB_AW-1:0] addr, input logic [31:0] exp,
                                input string name);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, 32'h0, rdata, err);
    check32(name, rdata, exp);
    check32("pslverr", {31'b0, err}, 32'h0);
  endtask

  // Random bytes for the spare rows
  task automatic make_random_row(input int i);
    logic [31:0] r;
    for (int k = 0; k < row_words[i]; k++)
    begin
      r = $random(seed);
      row_l0[i][16*k +: 16] = r[15:0];
      row_l1[i][16*k +: 16] = r[31:16];
    end
    row_cnt[i] = 8'(row_words[i]);
  endtask

  // Bank contents by the capture rules in byte order {l1 hi, l0 hi, l1 lo, l0 lo}
  task automatic update_model(input int i);
    logic [15:0] w0;
    logic [15:0] w1;
    if (row_en[i] && row_mask[i])
    begin
      for (int k = 0; k < row_words[i]; k++)
      begin
        w0 = row_l0[i][16*k +: 16];
        w1 = row_l1[i][16*k +: 16];
        model_bank[k % BANK_DEPTH] = {w1[15:8], w0[15:8], w1[7:0], w0[7:0]};
      end
    end
    if (row_rnd[i])
      row_exp[i] = {model_bank[2], model_bank[1], model_bank[0]};
  endtask

  task automatic drive_burst(input int i);
    logic [15:0] w0;
    logic [15:0] w1;
    s_rd_dqs_mask = row_mask[i];
    tick();
    for (int k = 0; k < row_words[i]; k++)
    begin
      w0 = row_l0[i][16*k +: 16];
      w1 = row_l1[i][16*k +: 16];
      s_data_rd = {w1[7:0], w0[7:0]};    // Rising strobe byte
      s_dqs_rd  = 2'b11;
      repeat (HOLD_CYCLES) tick();
      s_data_rd = {w1[15:8], w0[15:8]};
      s_dqs_rd  = 2'b00;
      repeat (HOLD_CYCLES) tick();
    end
    s_rd_dqs_mask = 1'b0;
    tick();
  endtask

  task automatic read_bank(input int i);
    check32("s_rd_data entry 0", s_rd_data, row_exp[i][31:0]);
    s_rd_pop = 1'b1;
    tick();
    s_rd_pop = 1'b0;
    check32("s_rd_data entry 1", s_rd_data, row_exp[i][63:32]);
    s_rd_pop = 1'b1;
    tick();
    s_rd_pop = 1'b0;
    check32("s_rd_data entry 2", s_rd_data, row_exp[i][95:64]);
    s_rd_end = 1'b1;                     // Pointer back to entry 0
    tick();
    s_rd_end = 1'b0;
    check32("s_rd_data after end", s_rd_data, row_exp[i][31:0]);
  endtask

  task automatic run_row(input int i);
    if (row_rnd[i])
      make_random_row(i);
    update_model(i);
    apb_write(CTRL_OFS, {31'b0, row_en[i]});
    apb_write(TAP_OFS, {{(32 - TAP_W){1'b0}}, row_tap[i]});
    s_rd_start = 1'b1;
    tick();
    s_rd_start = 1'b0;
    drive_burst(i);
    read_bank(i);
    apb_read_check(STAT_OFS, {16'b0, row_cnt[i], row_cnt[i]}, "prdata STAT");
  endtask

  initial
  begin
    logic [31:0] rdata;
    logic        err;
    hresetn       = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    s_dqs_rd      = '0;
    s_data_rd     = '0;
    s_rd_dqs_mask = 1'b0;
    s_rd_start    = 1'b0;
    s_rd_pop      = 1'b0;
    s_rd_end      = 1'b0;
    for (int b = 0; b < BANK_DEPTH; b++)
      model_bank[b] = '0;
    load_table();
    repeat (16) @(posedge dly_dqs_proc);
    #1;
    hresetn = 1'b1;
    tick();

    // Reset state
    check32("s_rd_data", s_rd_data, 32'h0);
    check32("pready", {31'b0, pready}, 32'h0);
    check32("pslverr", {31'b0, pslverr}, 32'h0);
    apb_read_check(STAT_OFS, 32'h0, "prdata STAT");
    apb_read_check(CTRL_OFS, 32'h0, "prdata CTRL");
    apb_read_check(TAP_OFS, 32'h0, "prdata TAP");

    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);

    // Unmapped offset gives an error and leaves the registers alone
    apb_access(1'b1, 4'hC, 32'h0, rdata, err);
    check32("pslverr", {31'b0, err}, 32'h1);
    apb_access(1'b0, 4'hC, 32'h0, rdata, err);
    check32("pslverr", {31'b0, err}, 32'h1);
    check32("prdata", rdata, 32'h0);
    apb_read_check(CTRL_OFS, {31'b0, row_en[NUM_ROWS-1]}, "prdata CTRL");
    apb_read_check(TAP_OFS, {{(32 - TAP_W){1'b0}}, row_tap[NUM_ROWS-1]}, "prdata TAP");

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* rd_capture_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rd_capture_top
  import rd_capture_pkg::*;
#(
  parameter int TAP_W      = rd_capture_pkg::TAP_W,
  parameter int BANK_DEPTH = rd_capture_pkg::BANK_DEPTH
) (
  input  wire                      dly_dqs_proc,
  input  wire                      hresetn,
  // APB slave
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  wire  [APB_AW-1:0]        paddr,
  input  wire  [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  // DDR read side
  input  wire  [LANES-1:0]         s_dqs_rd,
  input  wire  [LANES*LANE_W-1:0]  s_data_rd,   // Lane 0 in the low byte
  input  wire                      s_rd_dqs_mask,
  // Controller strobes
  input  wire                      s_rd_start,
  input  wire                      s_rd_pop,
  input  wire                      s_rd_end,
  output logic [RD_W-1:0]          s_rd_data
);

  logic              sample_en;
  logic [TAP_W-1:0]  tap;
  logic [WORD_W-1:0] word0;
  logic [WORD_W-1:0] word1;
  logic [CNT_W-1:0]  cnt0;
  logic [CNT_W-1:0]  cnt1;

  apb_capture_regs i_regs (
    .dly_dqs_proc (dly_dqs_proc),
    .hresetn      (hresetn),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .lane0_cnt    (cnt0),
    .lane1_cnt    (cnt1),
    .sample_en    (sample_en),
    .tap          (tap)
  );

  rd_byte_lane #(
    .TAP_W        (TAP_W),
    .BANK_DEPTH   (BANK_DEPTH)
  ) i_lane0 (
    .dly_dqs_proc (dly_dqs_proc),
    .hresetn      (hresetn),
    .dqs          (s_dqs_rd[0]),
    .mask         (s_rd_dqs_mask),
    .data         (s_data_rd[LANE_W-1:0]),
    .sample_en    (sample_en),
    .tap          (tap),
    .rd_start     (s_rd_start),
    .rd_pop       (s_rd_pop),
    .rd_end       (s_rd_end),
    .word         (word0),
    .capture_cnt  (cnt0)
  );

  rd_byte_lane #(
    .TAP_W        (TAP_W),
    .BANK_DEPTH   (BANK_DEPTH)
  ) i_lane1 (
    .dly_dqs_proc (dly_dqs_proc),
    .hresetn      (hresetn),
    .dqs          (s_dqs_rd[1]),
    .mask         (s_rd_dqs_mask),
    .data         (s_data_rd[2*LANE_W-1:LANE_W]),
    .sample_en    (sample_en),
    .tap          (tap),
    .rd_start     (s_rd_start),
    .rd_pop       (s_rd_pop),
    .rd_end       (s_rd_end),
    .word         (word1),
    .capture_cnt  (cnt1)
  );

  // High bytes in the upper half, low bytes in the lower half
  assign s_rd_data = {word1[WORD_W-1:LANE_W], word0[WORD_W-1:LANE_W],
                      word1[LANE_W-1:0], word0[LANE_W-1:0]};

endmodule

`default_nettype wire

/* apb_capture_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_capture_regs
  import rd_capture_pkg::*;
(
  input  wire               dly_dqs_proc,
  input  wire               hresetn,
  input  wire               psel,
  input  wire               penable,
  input  wire               pwrite,
  input  wire  [APB_AW-1:0] paddr,
  input  wire  [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  input  wire  [CNT_W-1:0]  lane0_cnt,
  input  wire  [CNT_W-1:0]  lane1_cnt,
  output logic              sample_en,
  output logic [TAP_W-1:0]  tap
);

  logic setup;
  logic addr_ok;
  logic wr_en;

  assign setup   = psel & ~penable;
  assign addr_ok = (paddr == CTRL_OFS) || (paddr == TAP_OFS) || (paddr == STAT_OFS);

  // Response flags are set up one cycle ahead, so they sit in the access phase
  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
    begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end
    else
    begin
      pready  <= setup;
      pslverr <= setup & ~addr_ok;
    end
  end

  assign wr_en = psel & penable & pready & pwrite & addr_ok;

  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
    begin
      sample_en <= 1'b0;
      tap       <= '0;
    end
    else if (wr_en)
    begin
      if (paddr == CTRL_OFS)
        sample_en <= pwdata[0];
      if (paddr == TAP_OFS)
        tap <= pwdata[TAP_W-1:0];
    end
  end

  // Read data, zero outside a good access phase
  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
      prdata <= '0;
    else if (setup && !pwrite)
    begin
      case (paddr)
        CTRL_OFS: prdata <= {31'b0, sample_en};
        TAP_OFS:  prdata <= {{(32 - TAP_W){1'b0}}, tap};
        STAT_OFS: prdata <= {{(32 - 2 * CNT_W){1'b0}}, lane1_cnt, lane0_cnt};
        default:  prdata <= '0;
      endcase
    end
    else
      prdata <= '0;
  end

endmodule

`default_nettype wire

/* rd_byte_lane.sv */
`timescale 1ns/10ps
`default_nettype none

module rd_byte_lane
  import rd_capture_pkg::*;
#(
  parameter int TAP_W      = rd_capture_pkg::TAP_W,
  parameter int BANK_DEPTH = rd_capture_pkg::BANK_DEPTH
) (
  input  wire               dly_dqs_proc,
  input  wire               hresetn,
  input  wire               dqs,
  input  wire               mask,
  input  wire  [LANE_W-1:0] data,
  input  wire               sample_en,
  input  wire  [TAP_W-1:0]  tap,
  input  wire               rd_start,
  input  wire               rd_pop,
  input  wire               rd_end,
  output logic [WORD_W-1:0] word,
  output logic [CNT_W-1:0]  capture_cnt
);

  localparam int PTR_W = $clog2(BANK_DEPTH);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(BANK_DEPTH - 1);

  logic              dqs_dly;
  logic              mask_dly;
  logic              dqs_dly_q;     // Previous delayed strobe
  logic              edge_ok;
  logic              rise;
  logic              fall;
  logic [LANE_W-1:0] low_byte;      // Byte from the rising edge
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [WORD_W-1:0] bank [BANK_DEPTH];

  dqs_delay_line #(
    .TAP_W        (TAP_W)
  ) i_dqs_delay_line (
    .dly_dqs_proc (dly_dqs_proc),
    .hresetn      (hresetn),
    .dqs_in       (dqs),
    .mask_in      (mask),
    .tap          (tap),
    .dqs_out      (dqs_dly),
    .mask_out     (mask_dly)
  );

  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
      dqs_dly_q <= 1'b0;
    else
      dqs_dly_q <= dqs_dly;
  end

  // Only edges inside the read window count
  assign edge_ok = mask_dly & sample_en;
  assign rise    = edge_ok & dqs_dly & ~dqs_dly_q;
  assign fall    = edge_ok & ~dqs_dly & dqs_dly_q;

  always_ff @(posedge dly_dqs_proc)
  begin
    if (rise)
      low_byte <= data;
  end

  // Bank write side, rotating over the entries
  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
    begin
      wr_ptr      <= '0;
      capture_cnt <= '0;
      for (int i = 0; i < BANK_DEPTH; i++)
        bank[i] <= '0;
    end
    else if (rd_start)
    begin
      wr_ptr      <= '0;
      capture_cnt <= '0;
    end
    else if (fall)
    begin
      bank[wr_ptr] <= {data, low_byte};          // Falling byte on top
      wr_ptr       <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      capture_cnt  <= capture_cnt + 1'b1;        // Wraps at 255
    end
  end

  // Read pointer moved by the controller strobes
  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
      rd_ptr <= '0;
    else if (rd_start || rd_end)
      rd_ptr <= '0;
    else if (rd_pop)
      rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
  end

  assign word = bank[rd_ptr];   // Same-cycle read select

endmodule

`default_nettype wire

/* dqs_delay_line.sv */
`timescale 1ns/10ps
`default_nettype none

module dqs_delay_line #(
  parameter int TAP_W = 3
) (
  input  wire              dly_dqs_proc,
  input  wire              hresetn,
  input  wire              dqs_in,
  input  wire              mask_in,
  input  wire  [TAP_W-1:0] tap,
  output logic             dqs_out,
  output logic             mask_out
);

  localparam int STAGES = 2 ** TAP_W;

  logic                  dqs_in_q;
  logic                  mask_in_q;
  logic [2*STAGES-1:0]   chain;       // {mask, dqs} pairs, stage 0 at the bottom
  logic [2*STAGES-1:0]   chain_nxt;

  // Samples enter at the tap stage and walk down to stage 0,
  // so the tap in force at entry fixes their delay
  always_comb
  begin
    chain_nxt = {2'b00, chain[2*STAGES-1:2]};
    chain_nxt[2*tap +: 2] = {mask_in_q, dqs_in_q};
  end

  always_ff @(posedge dly_dqs_proc or negedge hresetn)
  begin
    if (!hresetn)
    begin
      dqs_in_q  <= 1'b0;
      mask_in_q <= 1'b0;
      chain     <= '0;
    end
    else
    begin
      dqs_in_q  <= dqs_in;     // Input sampling stage
      mask_in_q <= mask_in;
      chain     <= chain_nxt;
    end
  end

  assign dqs_out  = chain[0];
  assign mask_out = chain[1];

endmodule

`default_nettype wire

/* rd_capture_pkg.sv */
`default_nettype none

package rd_capture_pkg;

  // DDR lane geometry
  localparam int LANE_W = 8;                 // One byte lane
  localparam int LANES  = 2;
  localparam int WORD_W = 2 * LANE_W;        // Rising and falling byte
  localparam int RD_W   = LANES * WORD_W;    // Interleaved read word

  // Capture bank and strobe delay
  localparam int BANK_DEPTH = 3;
  localparam int TAP_W      = 3;             // Taps 0 to 7
  localparam int CNT_W      = 8;

  // APB register map
  localparam int APB_AW = 4;

  localparam logic [APB_AW-1:0] CTRL_OFS = 4'h0;  // Bit 0 sample enable
  localparam logic [APB_AW-1:0] TAP_OFS  = 4'h4;  // Delay tap code
  localparam logic [APB_AW-1:0] STAT_OFS = 4'h8;  // Capture counts, read only

endpackage

`default_nettype wire
